// File: include/mem_bridge_settings.svh
`ifndef MEM_BRIDGE_SETTINGS_SVH
`define MEM_BRIDGE_SETTINGS_SVH

// bus widths
`define MB_ADDR_W 32
`define MB_DATA_W 32

// queue depths in entries
`define MB_REQ_DEPTH 4
`define MB_RSP_DEPTH 2

`endif

// File: verilog/axi_types_pkg.sv
package axi_types_pkg;

    // AxSIZE is log2 of the bytes per beat
    typedef enum logic [2:0] {
        SIZE_BYTE = 3'd0,
        SIZE_HALF = 3'd1,
        SIZE_WORD = 3'd2
    } axsize_e;

    // AxLEN holds beats minus one
    localparam logic [7:0] SINGLE_BEAT_LEN = 8'd0;

endpackage

// File: verilog/mem_req_pkg.sv
`include "mem_bridge_settings.svh"

package mem_req_pkg;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_e;

    // one queued datapath access
    typedef struct packed {
        op_e                      op;
        logic [`MB_ADDR_W-1:0]    addr;
        logic [`MB_DATA_W-1:0]    wdata;
        logic [`MB_DATA_W/8-1:0]  strb;   // zero for reads
    } req_entry_t;

endpackage

// File: verilog/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t wdata,
    input  logic     pop,
    output payload_t head,
    output logic     full,
    output logic     empty
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    // storage array
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // first word fall through
    assign head  = mem[rd_ptr];
    assign full  = (count == cnt_w'(depth));
    assign empty = (count == '0);

endmodule

// File: verilog/data_port.sv
`timescale 1ns/10ps
`include "mem_bridge_settings.svh"

module data_port (
    input  logic                      clk,
    input  logic                      rst_n,

    // datapath load/store port
    input  logic                      data_en,
    input  logic [`MB_ADDR_W-1:0]     data_addr,
    input  logic [`MB_DATA_W/8-1:0]   data_wen,
    input  logic [`MB_DATA_W-1:0]     data_wdata,
    output logic [`MB_DATA_W-1:0]     data_rdata,
    output logic                      stall,

    // request queue write side
    output logic                      req_push,
    output mem_req_pkg::req_entry_t   req_entry,
    input  logic                      req_full,

    // response queue read side
    output logic                      rsp_pop,
    input  logic [`MB_DATA_W-1:0]     rsp_head,
    input  logic                      rsp_empty
);

    logic is_read;
    logic is_write;
    logic read_pending;   // read queued, data not yet returned

    assign is_write = data_en & (|data_wen);
    assign is_read  = data_en & ~(|data_wen);

    // a stalled read goes into the queue only once
    assign req_push = (is_write | (is_read & ~read_pending)) & ~req_full;

    // at most one read in flight so any response is ours
    assign rsp_pop = read_pending & ~rsp_empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_pending <= 1'b0;
        end else if (req_push && is_read) begin
            read_pending <= 1'b1;
        end else if (rsp_pop) begin
            read_pending <= 1'b0;
        end
    end

    always_comb begin
        req_entry.op    = is_write ? mem_req_pkg::OP_WRITE : mem_req_pkg::OP_READ;
        req_entry.addr  = data_addr;
        req_entry.wdata = data_wdata;
        req_entry.strb  = data_wen;
    end

    // posted writes only wait on queue space
    assign stall = (is_write & req_full) | (is_read & ~rsp_pop);

    assign data_rdata = rsp_head;

endmodule

// File: verilog/axi_single_master.sv
`timescale 1ns/10ps
`include "mem_bridge_settings.svh"

module axi_single_master (
    input  logic                      clk,
    input  logic                      rst_n,

    // request queue read side
    output logic                      req_pop,
    input  mem_req_pkg::req_entry_t   req_head,
    input  logic                      req_empty,

    // response queue write side
    output logic                      rsp_push,
    output logic [`MB_DATA_W-1:0]     rsp_wdata,
    input  logic                      rsp_full,

    // read address
    output logic [`MB_ADDR_W-1:0]     araddr,
    output logic [7:0]                arlen,
    output logic                      arvalid,
    input  logic                      arready,

    // read data
    input  logic [`MB_DATA_W-1:0]     rdata,
    input  logic                      rlast,
    input  logic                      rvalid,
    output logic                      rready,

    // write address
    output logic [`MB_ADDR_W-1:0]     awaddr,
    output logic [7:0]                awlen,
    output logic [2:0]                awsize,
    output logic                      awvalid,
    input  logic                      awready,

    // write data
    output logic [`MB_DATA_W-1:0]     wdata,
    output logic [`MB_DATA_W/8-1:0]   wstrb,
    output logic                      wlast,
    output logic                      wvalid,
    input  logic                      wready,

    // write response
    input  logic                      bvalid,
    output logic                      bready
);

    mem_req_pkg::req_entry_t cur;   // request in flight
    axi_types_pkg::axsize_e  size_code;

    logic busy;
    logic raddr_rcv;   // ar handshake done
    logic waddr_rcv;   // aw handshake done
    logic wdata_rcv;   // w handshake done
    logic cur_read;
    logic cur_write;
    logic read_finish;
    logic write_finish;

    assign cur_read  = busy & (cur.op == mem_req_pkg::OP_READ);
    assign cur_write = busy & (cur.op == mem_req_pkg::OP_WRITE);

    assign req_pop = ~busy & ~req_empty;

    always_ff @(posedge clk) begin
        if (req_pop) begin
            cur <= req_head;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            raddr_rcv <= 1'b0;
            waddr_rcv <= 1'b0;
            wdata_rcv <= 1'b0;
        end else begin
            if (req_pop) begin
                busy <= 1'b1;
            end else if (read_finish || write_finish) begin
                busy <= 1'b0;   // idle for one cycle
            end
            raddr_rcv <= read_finish  ? 1'b0 : (raddr_rcv | (arvalid & arready));
            waddr_rcv <= write_finish ? 1'b0 : (waddr_rcv | (awvalid & awready));
            wdata_rcv <= write_finish ? 1'b0 : (wdata_rcv | (wvalid & wready & wlast));
        end
    end

    assign read_finish  = raddr_rcv & rvalid & rready & rlast;
    assign write_finish = waddr_rcv & wdata_rcv & bvalid & bready;

    // read channels
    assign araddr  = cur.addr;
    assign arlen   = axi_types_pkg::SINGLE_BEAT_LEN;
    assign arvalid = cur_read & ~raddr_rcv;
    assign rready  = cur_read & raddr_rcv & ~rsp_full;   // hold off while no room

    assign rsp_push  = read_finish;
    assign rsp_wdata = rdata;

    // size from the byte enables
    always_comb begin
        if (cur.strb == 4'b1111) begin
            size_code = axi_types_pkg::SIZE_WORD;
        end else if (cur.strb == 4'b0011 || cur.strb == 4'b1100) begin
            size_code = axi_types_pkg::SIZE_HALF;
        end else begin
            size_code = axi_types_pkg::SIZE_BYTE;
        end
    end

    // write channels
    assign awaddr  = cur.addr;
    assign awlen   = axi_types_pkg::SINGLE_BEAT_LEN;
    assign awsize  = size_code;
    assign awvalid = cur_write & ~waddr_rcv;
    assign wdata   = cur.wdata;
    assign wstrb   = cur.strb;
    assign wlast   = 1'b1;
    assign wvalid  = cur_write & ~wdata_rcv;
    assign bready  = cur_write & waddr_rcv & wdata_rcv;

endmodule

// File: verilog/mem_bridge_top.sv
`timescale 1ns/10ps
`include "mem_bridge_settings.svh"

module mem_bridge_top (
    input  logic                      clk,
    input  logic                      rst_n,

    // datapath
    input  logic                      data_en,
    input  logic [`MB_ADDR_W-1:0]     data_addr,
    input  logic [`MB_DATA_W/8-1:0]   data_wen,
    input  logic [`MB_DATA_W-1:0]     data_wdata,
    output logic [`MB_DATA_W-1:0]     data_rdata,
    output logic                      stall,

    // AXI read
    output logic [`MB_ADDR_W-1:0]     araddr,
    output logic [7:0]                arlen,
    output logic                      arvalid,
    input  logic                      arready,
    input  logic [`MB_DATA_W-1:0]     rdata,
    input  logic                      rlast,
    input  logic                      rvalid,
    output logic                      rready,

    // AXI write
    output logic [`MB_ADDR_W-1:0]     awaddr,
    output logic [7:0]                awlen,
    output logic [2:0]                awsize,
    output logic                      awvalid,
    input  logic                      awready,
    output logic [`MB_DATA_W-1:0]     wdata,
    output logic [`MB_DATA_W/8-1:0]   wstrb,
    output logic                      wlast,
    output logic                      wvalid,
    input  logic                      wready,
    input  logic                      bvalid,
    output logic                      bready
);

    mem_req_pkg::req_entry_t req_entry;
    mem_req_pkg::req_entry_t req_head;
    logic                    req_push;
    logic                    req_pop;
    logic                    req_full;
    logic                    req_empty;

    logic [`MB_DATA_W-1:0]   rsp_wdata;
    logic [`MB_DATA_W-1:0]   rsp_head;
    logic                    rsp_push;
    logic                    rsp_pop;
    logic                    rsp_full;
    logic                    rsp_empty;

    data_port u_data_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_en    (data_en),
        .data_addr  (data_addr),
        .data_wen   (data_wen),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .stall      (stall),
        .req_push   (req_push),
        .req_entry  (req_entry),
        .req_full   (req_full),
        .rsp_pop    (rsp_pop),
        .rsp_head   (rsp_head),
        .rsp_empty  (rsp_empty)
    );

    sync_fifo #(
        .payload_t (mem_req_pkg::req_entry_t),
        .depth     (`MB_REQ_DEPTH)
    ) u_req_queue (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (req_push),
        .wdata (req_entry),
        .pop   (req_pop),
        .head  (req_head),
        .full  (req_full),
        .empty (req_empty)
    );

    // return path for read data
    sync_fifo #(
        .payload_t (logic [`MB_DATA_W-1:0]),
        .depth     (`MB_RSP_DEPTH)
    ) u_rsp_queue (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (rsp_push),
        .wdata (rsp_wdata),
        .pop   (rsp_pop),
        .head  (rsp_head),
        .full  (rsp_full),
        .empty (rsp_empty)
    );

    axi_single_master u_axi_master (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_pop   (req_pop),
        .req_head  (req_head),
        .req_empty (req_empty),
        .rsp_push  (rsp_push),
        .rsp_wdata (rsp_wdata),
        .rsp_full  (rsp_full),
        .araddr    (araddr),
        .arlen     (arlen),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rlast     (rlast),
        .rvalid    (rvalid),
        .rready    (rready),
        .awaddr    (awaddr),
        .awlen     (awlen),
        .awsize    (awsize),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wlast     (wlast),
        .wvalid    (wvalid),
        .wready    (wready),
        .bvalid    (bvalid),
        .bready    (bready)
    );

endmodule

// File: test/mem_bridge_properties.sv
`timescale 1ns/10ps
`include "mem_bridge_settings.svh"

module mem_bridge_properties (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    data_en,
    input logic [`MB_DATA_W/8-1:0] data_wen,
    input logic                    stall,
    input logic                    req_full,
    input logic                    rsp_full,
    input logic                    arvalid,
    input logic                    arready,
    input logic [`MB_ADDR_W-1:0]   araddr,
    input logic [7:0]              arlen,
    input logic                    rvalid,
    input logic                    rlast,
    input logic                    rready,
    input logic                    awvalid,
    input logic                    awready,
    input logic [`MB_ADDR_W-1:0]   awaddr,
    input logic [7:0]              awlen,
    input logic [2:0]              awsize,
    input logic                    wvalid,
    input logic                    wready,
    input logic [`MB_DATA_W-1:0]   wdata,
    input logic [`MB_DATA_W/8-1:0] wstrb,
    input logic                    wlast,
    input logic                    bvalid,
    input logic                    bready
);

    int   fail_count = 0;   // failed assertion count
    logic ar_done;          // ar handshake seen for the current read
    logic aw_done;          // aw handshake seen for the current write
    logic w_done;
    logic quiet;

    function automatic void flag_failure(input string what);
        fail_count++;
        $error("%s", what);
    endfunction

    // AXI size code for a strobe pattern
    function automatic logic [2:0] size_for(input logic [3:0] strb);
        case (strb)
            4'b1111:          return 3'd2;
            4'b0011, 4'b1100: return 3'd1;
            default:          return 3'd0;
        endcase
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_done <= 1'b0;
        end else if (rvalid && rready && rlast) begin
            ar_done <= 1'b0;
        end else begin
            ar_done <= ar_done | (arvalid & arready);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else if (bvalid && bready) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            aw_done <= aw_done | (awvalid & awready);
            w_done  <= w_done | (wvalid & wready);
        end
    end

    assign quiet = !(arvalid || awvalid || wvalid || rready || bready || stall);

    reset_quiet: assert property (@(posedge clk) !rst_n |-> quiet)
        else flag_failure("valid, ready or stall high during reset");
    release_quiet: assert property (@(posedge clk) $rose(rst_n) |-> quiet)
        else flag_failure("valid, ready or stall high on first edge after reset");

    single_beat_ar: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid |-> arlen == 8'd0)
        else flag_failure("arlen is not zero");
    single_beat_aw: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid |-> awlen == 8'd0)
        else flag_failure("awlen is not zero");
    last_beat_w: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid |-> wlast)
        else flag_failure("wlast low on a write beat");

    ar_held: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else flag_failure("arvalid or araddr changed before handshake");
    aw_held: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awsize))
        else flag_failure("awvalid or aw payload changed before handshake");
    w_held: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
        else flag_failure("wvalid or w payload changed before handshake");

    size_rule: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid |-> awsize == size_for(wstrb))
        else flag_failure("awsize does not match the strobe pattern");

    b_after_aw_w: assert property (@(posedge clk) disable iff (!rst_n)
        bready |-> aw_done && w_done)
        else flag_failure("bready raised before both aw and w handshakes");
    r_needs_room: assert property (@(posedge clk) disable iff (!rst_n)
        rready |-> ar_done && !rsp_full)
        else flag_failure("rready high without an accepted read or with the response queue full");

    write_stall: assert property (@(posedge clk) disable iff (!rst_n)
        data_en && data_wen != '0 |-> stall == req_full)
        else flag_failure("write stall differs from request queue full");
    read_stall: assert property (@(posedge clk) disable iff (!rst_n)
        data_en && data_wen == '0 && !$past(stall) |-> stall ##1 stall)
        else flag_failure("read stalled for fewer than two cycles");

endmodule

// File: test/mem_bridge_tb.sv
`timescale 1ns/10ps
`include "mem_bridge_settings.svh"

module mem_bridge_tb;

    localparam int n_access       = 400;
    localparam int n_write_burst  = 40;   // back to back stores up front
    localparam int timeout_cycles = n_access * 40;

    logic                    clk;
    logic                    rst_n;
    logic                    data_en;
    logic [`MB_ADDR_W-1:0]   data_addr;
    logic [`MB_DATA_W/8-1:0] data_wen;
    logic [`MB_DATA_W-1:0]   data_wdata;
    logic [`MB_DATA_W-1:0]   data_rdata;
    logic                    stall;
    logic [`MB_ADDR_W-1:0]   araddr;
    logic [7:0]              arlen;
    logic                    arvalid;
    logic                    arready = 1'b0;
    logic [`MB_DATA_W-1:0]   rdata = '0;
    logic                    rlast = 1'b0;
    logic                    rvalid = 1'b0;
    logic                    rready;
    logic [`MB_ADDR_W-1:0]   awaddr;
    logic [7:0]              awlen;
    logic [2:0]              awsize;
    logic                    awvalid;
    logic                    awready = 1'b0;
    logic [`MB_DATA_W-1:0]   wdata;
    logic [`MB_DATA_W/8-1:0] wstrb;
    logic                    wlast;
    logic                    wvalid;
    logic                    wready = 1'b0;
    logic                    bvalid = 1'b0;
    logic                    bready;

    // slave model state
    logic [31:0] slave_mem [16];
    logic        rd_busy;
    logic [3:0]  rd_idx;
    int          rd_wait;
    logic        aw_got;
    logic        w_got;
    logic [3:0]  wr_idx;
    logic [31:0] wr_data;
    logic [3:0]  wr_strb;
    logic        b_pend;
    int          b_wait;

    // reference side
    logic [31:0] shadow [16];
    logic [31:0] exp_waddr [$];   // stores accepted but not yet answered on b
    logic [3:0]  exp_wstrb [$];
    int          error_count = 0;
    int          cycle_count;

    mem_bridge_top i_dut (.*);

    bind mem_bridge_top mem_bridge_properties u_props (
        .clk      (clk),
        .rst_n    (rst_n),
        .data_en  (data_en),
        .data_wen (data_wen),
        .stall    (stall),
        .req_full (req_full),
        .rsp_full (rsp_full),
        .arvalid  (arvalid),
        .arready  (arready),
        .araddr   (araddr),
        .arlen    (arlen),
        .rvalid   (rvalid),
        .rlast    (rlast),
        .rready   (rready),
        .awvalid  (awvalid),
        .awready  (awready),
        .awaddr   (awaddr),
        .awlen    (awlen),
        .awsize   (awsize),
        .wvalid   (wvalid),
        .wready   (wready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wlast    (wlast),
        .bvalid   (bvalid),
        .bready   (bready)
    );

    // start-up contents depend on every address bit
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr ^ 32'hc3a5_5a3c) * 32'h0101_0111;
    endfunction

    task automatic run_access(input logic [31:0] addr, input logic [3:0] wen,
                              input logic [31:0] wdat);
        data_en    <= 1'b1;
        data_addr  <= addr;
        data_wen   <= wen;
        data_wdata <= wdat;
        @(posedge clk);
        while (stall) begin
            @(posedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // AXI slave with random ready and response delays
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            rdata   <= '0;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            rd_busy <= 1'b0;
            rd_wait <= 0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            b_pend  <= 1'b0;
            b_wait  <= 0;
            for (int k = 0; k < 16; k++) begin
                slave_mem[k] <= fill_word(32'(k * 4));
            end
        end else begin
            if (arvalid && arready) begin
                arready <= 1'b0;
                rd_busy <= 1'b1;
                rd_idx  <= araddr[5:2];
                rd_wait <= $urandom % 4;
            end else if (!rd_busy) begin
                arready <= ($urandom % 2) == 0;
            end
            if (rd_busy && !rvalid) begin
                if (rd_wait == 0) begin
                    rvalid <= 1'b1;
                    rlast  <= 1'b1;
                    rdata  <= slave_mem[rd_idx];
                end else begin
                    rd_wait <= rd_wait - 1;
                end
            end
            if (rvalid && rready) begin
                rvalid  <= 1'b0;
                rlast   <= 1'b0;
                rd_busy <= 1'b0;
            end

            if (awvalid && awready) begin
                awready <= 1'b0;
                aw_got  <= 1'b1;
                wr_idx  <= awaddr[5:2];
            end else if (!aw_got) begin
                awready <= ($urandom % 2) == 0;
            end
            if (wvalid && wready) begin
                wready  <= 1'b0;
                w_got   <= 1'b1;
                wr_data <= wdata;
                wr_strb <= wstrb;
            end else if (!w_got) begin
                wready <= ($urandom % 2) == 0;
            end
            if (aw_got && w_got && !b_pend) begin
                for (int b = 0; b < 4; b++) begin
                    if (wr_strb[b]) begin
                        slave_mem[wr_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
                    end
                end
                b_pend <= 1'b1;
                b_wait <= $urandom % 3;
            end
            if (b_pend && !bvalid) begin
                if (b_wait == 0) begin
                    bvalid <= 1'b1;
                end else begin
                    b_wait <= b_wait - 1;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                b_pend <= 1'b0;
                aw_got <= 1'b0;
                w_got  <= 1'b0;
            end
        end
    end

    // shadow memory and datapath-side checks
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < 16; k++) begin
                shadow[k] <= fill_word(32'(k * 4));
            end
        end else begin
            if (awvalid) begin
                write_queued: assert (exp_waddr.size() != 0) else begin
                    error_count++;
                    $display("unexpected AXI write to 0x%08h with no store pending", awaddr);
                end
                if (exp_waddr.size() != 0) begin
                    write_match: assert (awaddr == exp_waddr[0] && wstrb == exp_wstrb[0])
                    else begin
                        error_count++;
                        $display("** Error: %0d ns write 0x%08h strb %b, expected 0x%08h strb %b",
                                 $time, awaddr, wstrb, exp_waddr[0], exp_wstrb[0]);
                    end
                end
            end
            if (arvalid) begin
                read_addr_match: assert (araddr == data_addr) else begin
                    error_count++;
                    $display("** Error: %0d ns read address 0x%08h, expected 0x%08h",
                             $time, araddr, data_addr);
                end
            end
            if (bvalid && bready && exp_waddr.size() != 0) begin
                void'(exp_waddr.pop_front());
                void'(exp_wstrb.pop_front());
            end
            if (data_en && !stall) begin
                if (data_wen != 4'b0000) begin
                    for (int b = 0; b < 4; b++) begin
                        if (data_wen[b]) begin
                            shadow[data_addr[5:2]][b*8 +: 8] <= data_wdata[b*8 +: 8];
                        end
                    end
                    exp_waddr.push_back(data_addr);
                    exp_wstrb.push_back(data_wen);
                end else begin
                    read_match: assert (data_rdata == shadow[data_addr[5:2]]) else begin
                        error_count++;
                        $display("** Error: %0d ns read 0x%08h got 0x%08h, expected 0x%08h",
                                 $time, data_addr, data_rdata, shadow[data_addr[5:2]]);
                    end
                end
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run still busy after %0d cycles", timeout_cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] addr;
        logic [3:0]  wen;
        int          i;
        void'($urandom(4));
        rst_n      = 1'b0;
        data_en    = 1'b0;
        data_addr  = '0;
        data_wen   = '0;
        data_wdata = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        for (i = 0; i < n_access; i++) begin
            addr = 32'(($urandom % 16) * 4);
            wen  = 4'($urandom % 16);
            if (i >= n_write_burst && ($urandom % 5) < 2) begin
                wen = 4'b0000;   // read
            end else if (wen == 4'b0000) begin
                wen = 4'b1111;
            end
            run_access(addr, wen, $urandom);
            if (i >= n_write_burst && ($urandom % 4) == 0) begin
                data_en <= 1'b0;
                @(posedge clk);
            end
        end
        data_en <= 1'b0;

        // let the posted stores reach the bus
        repeat (2) @(posedge clk);
        while (exp_waddr.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);

        $display("summary: %0d data errors, %0d assertion failures",
                 error_count, i_dut.u_props.fail_count);
        if (error_count == 0 && i_dut.u_props.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: mem_bridge.f
+incdir+include
verilog/axi_types_pkg.sv
verilog/mem_req_pkg.sv
verilog/sync_fifo.sv
verilog/data_port.sv
verilog/axi_single_master.sv
verilog/mem_bridge_top.sv
test/mem_bridge_properties.sv
test/mem_bridge_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f mem_bridge.f --top-module mem_bridge_tb -o mem_bridge_sim

# raise the runtime error limit so assertion failures are counted, not fatal
status=0
./obj_dir/mem_bridge_sim +verilator+error+limit+10000 > "$log" 2>&1 || status=$?
cat "$log"

if [ "$status" -ne 0 ] || grep -q "SOME TESTS FAILED" "$log"; then
    echo "simulation failed, see $log"
    exit 1
fi
echo "simulation passed"
